// File: common/dcore_pkg.sv
`default_nettype none

package dcore_pkg;

    //////////////////////////////
    // decision path sizes
    //////////////////////////////

    // interleaved lanes and adc resolution
    localparam int N_TI   = 16;
    localparam int N_ADC  = 8;
    localparam int CODE_W = N_ADC + 1;

    // slices come in as a 4 by 4 grid
    localparam int REORDER_ROWS = 4;

    //////////////////////////////
    // pi control sizes
    //////////////////////////////

    localparam int N_OUT     = 4;
    localparam int N_PI      = 9;
    localparam int MAX_SEL_W = 4;

    // settle time after cdr reset
    localparam int WAIT_CYCLES = 32;
    localparam int WAIT_W      = 5;

    //////////////////////////////
    // histogram sizes
    //////////////////////////////

    localparam int HIST_W     = 32;
    localparam int N_LEVELS   = 4;
    localparam int LANE_CNT_W = 5;

    // one adc slice output, sign plus magnitude
    typedef struct packed {
        logic             sign;
        logic [N_ADC-1:0] mag;
    } adc_sample_t;

    // gray coded pam4 levels, msb is the sign
    typedef enum logic [1:0] {
        SYM_M3 = 2'b00,
        SYM_M1 = 2'b01,
        SYM_P1 = 2'b11,
        SYM_P3 = 2'b10
    } pam4_sym_e;

    // per output pi code mapping
    typedef struct packed {
        logic                 en_ext_max;
        logic [N_PI-1:0]      ext_max;
        logic [MAX_SEL_W-1:0] max_sel;
        logic [N_PI-1:0]      offset;
    } pi_cfg_t;

endpackage

`default_nettype wire

// File: verilog/adc_reorder.sv
`default_nettype none

module adc_reorder (
    input wire logic clk_adc,
    input wire logic cdr_rstb,
    input wire dcore_pkg::adc_sample_t adc_i [dcore_pkg::N_TI],

    output logic signed [dcore_pkg::CODE_W-1:0] lane_code_o [dcore_pkg::N_TI]
);

    // unfolded codes in lane order, before the register
    logic signed [dcore_pkg::CODE_W-1:0] unfolded [dcore_pkg::N_TI];

    //////////////////////////////
    // transpose and unfold
    //////////////////////////////

    // slices arrive column major, lanes leave row major
    for (genvar k = 0; k < dcore_pkg::N_TI; k++) begin : g_lane
        dcore_pkg::adc_sample_t smp;
        logic signed [dcore_pkg::CODE_W-1:0] mag_s;

        assign smp = adc_i[(k % dcore_pkg::REORDER_ROWS)
                           * (dcore_pkg::N_TI / dcore_pkg::REORDER_ROWS)
                           + k / dcore_pkg::REORDER_ROWS];

        // magnitude with a zero sign bit
        assign mag_s = $signed({1'b0, smp.mag});

        // sign high means a positive sample
        assign unfolded[k] = smp.sign ? mag_s : -mag_s;
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    // cleared so the slicers never see unknown codes
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                lane_code_o[k] <= '0;
            end
        end else begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                lane_code_o[k] <= unfolded[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: slicer/pam4_slicer.sv
`default_nettype none

module pam4_slicer (
    input wire logic clk_adc,
    input wire logic cdr_rstb,
    input wire logic signed [dcore_pkg::CODE_W-1:0] code_i,
    input wire logic [dcore_pkg::N_ADC-1:0] bit_level_i,

    output dcore_pkg::pam4_sym_e sym_o
);

    // threshold as a signed code
    logic signed [dcore_pkg::CODE_W-1:0] lvl_pos;

    // gray bits of the decision
    logic nonneg;
    logic inner;

    assign lvl_pos = $signed({1'b0, bit_level_i});

    //////////////////////////////
    // decision
    //////////////////////////////

    // msb of the gray code is the sign of the sample
    assign nonneg = !code_i[dcore_pkg::CODE_W-1];

    // lsb marks the two inner levels, thresholds included
    assign inner = (code_i <= lvl_pos) && (code_i >= -lvl_pos);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            sym_o <= dcore_pkg::SYM_M3;
        end else begin
            sym_o <= dcore_pkg::pam4_sym_e'({nonneg, inner});
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // unknown adc data or level upstream would show up here
    a_sym_known: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        !$isunknown(sym_o)
    ) else $error("pam4_slicer: sym_o is unknown");

endmodule

`default_nettype wire

// File: verilog/level_histogram.sv
`default_nettype none

module level_histogram (
    input wire logic clk_adc,
    input wire logic cdr_rstb,
    input wire dcore_pkg::pam4_sym_e sym_i [dcore_pkg::N_TI],
    input wire logic hist_en_i,
    input wire logic hist_clear_i,

    output logic [dcore_pkg::HIST_W-1:0] count_o [dcore_pkg::N_LEVELS]
);

    // lanes at each level in the current cycle
    logic [dcore_pkg::LANE_CNT_W-1:0] lane_cnt [dcore_pkg::N_LEVELS];
    int lane_sum;

    // lane counts and controls delayed one stage together
    logic [dcore_pkg::LANE_CNT_W-1:0] lane_cnt_q [dcore_pkg::N_LEVELS];
    logic en_q;
    logic clr_q;

    //////////////////////////////
    // per cycle lane count
    //////////////////////////////

    always_comb begin
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            lane_cnt[l] = '0;
        end
        for (int i = 0; i < dcore_pkg::N_TI; i++) begin
            lane_cnt[sym_i[i]] = lane_cnt[sym_i[i]] + 1'b1;
        end
        lane_sum = 0;
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            lane_sum = lane_sum + int'(lane_cnt[l]);
        end
    end

    //////////////////////////////
    // counters
    //////////////////////////////

    // enable and clear travel one stage with the symbols
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            en_q  <= 1'b0;
            clr_q <= 1'b0;
            for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
                lane_cnt_q[l] <= '0;
                count_o[l]    <= '0;
            end
        end else begin
            en_q  <= hist_en_i;
            clr_q <= hist_clear_i;
            for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
                lane_cnt_q[l] <= lane_cnt[l];
                // clear wins over counting
                if (clr_q) begin
                    count_o[l] <= '0;
                end else if (en_q) begin
                    count_o[l] <= count_o[l]
                        + {{(dcore_pkg::HIST_W - dcore_pkg::LANE_CNT_W){1'b0}}, lane_cnt_q[l]};
                end
            end
        end
    end

    // every lane lands in exactly one bin
    a_lane_sum: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        lane_sum == dcore_pkg::N_TI
    ) else $error("level_histogram: lane counts sum to %0d", lane_sum);

endmodule

`default_nettype wire

// File: verilog/pi_ctl_scaler.sv
`default_nettype none

module pi_ctl_scaler (
    input wire logic clk_adc,
    input wire logic cdr_rstb,
    input wire logic [dcore_pkg::N_PI-1:0] pi_ctl_i [dcore_pkg::N_OUT],
    input wire dcore_pkg::pi_cfg_t pi_cfg_i [dcore_pkg::N_OUT],

    output logic [dcore_pkg::N_PI-1:0] int_pi_ctl_o [dcore_pkg::N_OUT],
    output logic ctl_valid_o
);

    //////////////////////////////
    // wait after reset
    //////////////////////////////

    logic [dcore_pkg::WAIT_W-1:0] wait_cnt;
    logic wait_full;

    // counter parks on its last value
    assign wait_full = (32'(wait_cnt) == dcore_pkg::WAIT_CYCLES - 1);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt    <= '0;
            ctl_valid_o <= 1'b0;
        end else begin
            if (!wait_full) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            // high from the 32nd edge on
            ctl_valid_o <= wait_full;
        end
    end

    a_valid_holds: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_o |=> ctl_valid_o
    ) else $error("pi_ctl_scaler: ctl_valid_o fell outside reset");

    //////////////////////////////
    // pi code mapping
    //////////////////////////////

    for (genvar j = 0; j < dcore_pkg::N_OUT; j++) begin : g_out
        logic [dcore_pkg::N_PI-1:0] int_scale;
        logic [dcore_pkg::N_PI-1:0] sel_scale;
        logic [dcore_pkg::N_PI-1:0] wrapped;

        // analog max select in steps of 16 codes
        assign int_scale = (({{(dcore_pkg::N_PI - dcore_pkg::MAX_SEL_W){1'b0}},
                              pi_cfg_i[j].max_sel} + 1'b1) << 4) - 1'b1;

        assign sel_scale = pi_cfg_i[j].en_ext_max ? pi_cfg_i[j].ext_max : int_scale;

        assign wrapped = pi_ctl_i[j] % sel_scale;

        // offset may wrap past the top code
        assign int_pi_ctl_o[j] = wrapped + pi_cfg_i[j].offset;

        // a zero modulus has no defined result
        a_ext_max_nonzero: assert property (
            @(posedge clk_adc) disable iff (!cdr_rstb)
            !(pi_cfg_i[j].en_ext_max && (pi_cfg_i[j].ext_max == '0))
        ) else $error("pi_ctl_scaler: zero external scale on output %0d", j);
    end

endmodule

`default_nettype wire

// File: verilog/digital_core.sv
`default_nettype none

module digital_core (
    input wire logic clk_adc,
    input wire logic cdr_rstb,

    // adc slices in slice order
    input wire dcore_pkg::adc_sample_t adc_i [dcore_pkg::N_TI],

    // decision and histogram control
    input wire logic [dcore_pkg::N_ADC-1:0] bit_level_i,
    input wire logic hist_en_i,
    input wire logic hist_clear_i,

    // raw pi codes and their mapping
    input wire logic [dcore_pkg::N_PI-1:0] pi_ctl_i [dcore_pkg::N_OUT],
    input wire dcore_pkg::pi_cfg_t pi_cfg_i [dcore_pkg::N_OUT],

    output logic [2*dcore_pkg::N_TI-1:0] symbols_o,
    output logic [dcore_pkg::HIST_W-1:0] hist_count_o [dcore_pkg::N_LEVELS],
    output logic [dcore_pkg::N_PI-1:0] int_pi_ctl_o [dcore_pkg::N_OUT],
    output logic ctl_valid_o
);

    // signed codes in lane order
    logic signed [dcore_pkg::CODE_W-1:0] lane_code [dcore_pkg::N_TI];

    // sliced symbols per lane
    dcore_pkg::pam4_sym_e sym [dcore_pkg::N_TI];

    //////////////////////////////
    // decision path
    //////////////////////////////

    adc_reorder reorder_i (
        .clk_adc(clk_adc),
        .cdr_rstb(cdr_rstb),
        .adc_i(adc_i),
        .lane_code_o(lane_code)
    );

    for (genvar k = 0; k < dcore_pkg::N_TI; k++) begin : g_slice
        pam4_slicer slicer_i (
            .clk_adc(clk_adc),
            .cdr_rstb(cdr_rstb),
            .code_i(lane_code[k]),
            .bit_level_i(bit_level_i),
            .sym_o(sym[k])
        );

        // lane 0 in the low bits
        assign symbols_o[2*k +: 2] = sym[k];
    end

    level_histogram hist_i (
        .clk_adc(clk_adc),
        .cdr_rstb(cdr_rstb),
        .sym_i(sym),
        .hist_en_i(hist_en_i),
        .hist_clear_i(hist_clear_i),
        .count_o(hist_count_o)
    );

    //////////////////////////////
    // pi control path
    //////////////////////////////

    pi_ctl_scaler pi_scale_i (
        .clk_adc(clk_adc),
        .cdr_rstb(cdr_rstb),
        .pi_ctl_i(pi_ctl_i),
        .pi_cfg_i(pi_cfg_i),
        .int_pi_ctl_o(int_pi_ctl_o),
        .ctl_valid_o(ctl_valid_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_digital_core.sv
`default_nettype none

module tb_digital_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int VALID_TIMEOUT = 64;
    localparam int SMP_W = dcore_pkg::N_ADC + 1;
    localparam int RAW_W = dcore_pkg::N_TI * SMP_W;
    localparam int SYM_W = 2 * dcore_pkg::N_TI;

    // one cycle of decision path stimulus
    typedef struct packed {
        logic [dcore_pkg::N_ADC-1:0] bit_level;
        logic edge_mode;
        logic hist_en;
        logic hist_clr;
    } row_t;

    // one pi code with its mapping and the hand computed result
    typedef struct packed {
        logic [dcore_pkg::N_PI-1:0] code;
        dcore_pkg::pi_cfg_t cfg;
        logic [dcore_pkg::N_PI-1:0] exp_code;
    } pi_row_t;

    logic clk_adc;
    logic cdr_rstb;
    dcore_pkg::adc_sample_t adc_i [dcore_pkg::N_TI];
    logic [dcore_pkg::N_ADC-1:0] bit_level_i;
    logic hist_en_i;
    logic hist_clear_i;
    logic [dcore_pkg::N_PI-1:0] pi_ctl_i [dcore_pkg::N_OUT];
    dcore_pkg::pi_cfg_t pi_cfg_i [dcore_pkg::N_OUT];
    logic [SYM_W-1:0] symbols_o;
    logic [dcore_pkg::HIST_W-1:0] hist_count_o [dcore_pkg::N_LEVELS];
    logic [dcore_pkg::N_PI-1:0] int_pi_ctl_o [dcore_pkg::N_OUT];
    logic ctl_valid_o;

    // reference model state
    row_t rows [$];
    pi_row_t pi_rows [$];
    logic [RAW_W-1:0] raw_q [$];
    logic [SYM_W-1:0] sym_q [$];
    logic [SYM_W-1:0] vis_sym;
    logic [dcore_pkg::HIST_W-1:0] cnt_vis [dcore_pkg::N_LEVELS];
    logic [dcore_pkg::HIST_W-1:0] cnt_next [dcore_pkg::N_LEVELS];
    logic [dcore_pkg::N_PI-1:0] pi_exp [dcore_pkg::N_OUT];
    logic pi_known;
    logic [31:0] lfsr_state;
    logic timed_out;
    int n_checks;
    int n_errors;

    digital_core DUT (
        .clk_adc(clk_adc),
        .cdr_rstb(cdr_rstb),
        .adc_i(adc_i),
        .bit_level_i(bit_level_i),
        .hist_en_i(hist_en_i),
        .hist_clear_i(hist_clear_i),
        .pi_ctl_i(pi_ctl_i),
        .pi_cfg_i(pi_cfg_i),
        .symbols_o(symbols_o),
        .hist_count_o(hist_count_o),
        .int_pi_ctl_o(int_pi_ctl_o),
        .ctl_valid_o(ctl_valid_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever begin
            #2 clk_adc = ~clk_adc;
        end
    end

    //////////////////////////////
    // model helpers
    //////////////////////////////

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic fb;
        logic [31:0] val;
        val = '0;
        repeat (n) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [1:0] slice_code(input int v, input int lvl);
        if (v > lvl) begin
            return dcore_pkg::SYM_P3;
        end else if (v >= 0) begin
            return dcore_pkg::SYM_P1;
        end else if (v >= -lvl) begin
            return dcore_pkg::SYM_M1;
        end
        return dcore_pkg::SYM_M3;
    endfunction

    // lane k reads slice (k mod 4)*4 + k div 4
    function automatic logic [SYM_W-1:0] expected_symbols(input logic [RAW_W-1:0] raw,
                                                          input int lvl);
        logic [SYM_W-1:0] word;
        int slice;
        int v;
        word = '0;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            slice = (k % 4) * 4 + k / 4;
            v = int'(raw[slice*SMP_W +: dcore_pkg::N_ADC]);
            if (!raw[slice*SMP_W + dcore_pkg::N_ADC]) begin
                v = -v;
            end
            word[2*k +: 2] = slice_code(v, lvl);
        end
        return word;
    endfunction

    function automatic logic [31:0] count_level(input logic [SYM_W-1:0] word, input int lvl);
        logic [31:0] n;
        n = '0;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            if (int'(word[2*k +: 2]) == lvl) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        n_errors++;
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task automatic add_row(input int lvl, input bit edge_mode, input bit en, input bit clr);
        row_t r;
        r.bit_level = lvl[dcore_pkg::N_ADC-1:0];
        r.edge_mode = edge_mode;
        r.hist_en = en;
        r.hist_clr = clr;
        rows.push_back(r);
    endtask

    task automatic add_pi(input int code, input bit ext, input int ext_max, input int max_sel,
                          input int offset, input int exp_code);
        pi_row_t p;
        p.code = code[dcore_pkg::N_PI-1:0];
        p.cfg.en_ext_max = ext;
        p.cfg.ext_max = ext_max[dcore_pkg::N_PI-1:0];
        p.cfg.max_sel = max_sel[dcore_pkg::MAX_SEL_W-1:0];
        p.cfg.offset = offset[dcore_pkg::N_PI-1:0];
        p.exp_code = exp_code[dcore_pkg::N_PI-1:0];
        pi_rows.push_back(p);
    endtask

    task automatic build_tables();
        // level, edge codes, enable, clear
        add_row(40, 0, 0, 1);
        add_row(40, 0, 1, 0);
        add_row(40, 1, 1, 0);
        add_row(0, 1, 1, 0);
        add_row(0, 0, 0, 0);
        add_row(100, 0, 1, 0);
        add_row(255, 1, 1, 0);
        add_row(128, 0, 0, 0);
        add_row(128, 1, 1, 1);
        add_row(17, 0, 1, 0);
        add_row(17, 1, 1, 0);
        add_row(200, 0, 1, 0);
        add_row(64, 0, 0, 0);
        add_row(64, 0, 0, 0);
        add_row(64, 0, 0, 0);
        // code, ext, ext_max, max_sel, offset, expected
        add_pi(100, 0, 0, 0, 0, 10);
        add_pi(511, 0, 0, 15, 3, 4);
        add_pi(200, 0, 0, 7, 500, 61);
        add_pi(50, 0, 0, 3, 10, 60);
        add_pi(300, 1, 100, 0, 7, 7);
        add_pi(511, 1, 511, 2, 511, 511);
        add_pi(450, 1, 200, 9, 480, 18);
        add_pi(63, 0, 0, 3, 0, 0);
    endtask

    //////////////////////////////
    // drive and check
    //////////////////////////////

    task automatic drive_row(input int ri);
        row_t r;
        pi_row_t p;
        logic [RAW_W-1:0] raw;
        logic [31:0] bits;
        logic [dcore_pkg::HIST_W-1:0] tmp;
        int mag;
        r = rows[ri];
        raw = '0;
        for (int s = 0; s < dcore_pkg::N_TI; s++) begin
            if (r.edge_mode) begin
                // codes at and next to plus and minus the level, and zero
                case (s % 4)
                    0: mag = int'(r.bit_level);
                    1: mag = int'(r.bit_level) + 1;
                    2: mag = int'(r.bit_level) - 1;
                    default: mag = 0;
                endcase
                if (mag > 255) begin
                    mag = 255;
                end
                if (mag < 0) begin
                    mag = 0;
                end
                raw[s*SMP_W + dcore_pkg::N_ADC] = ((s / 4) % 2) == 1;
                raw[s*SMP_W +: dcore_pkg::N_ADC] = mag[dcore_pkg::N_ADC-1:0];
            end else begin
                bits = take_bits(SMP_W);
                raw[s*SMP_W +: SMP_W] = bits[SMP_W-1:0];
            end
            adc_i[s] = dcore_pkg::adc_sample_t'(raw[s*SMP_W +: SMP_W]);
        end
        bit_level_i = r.bit_level;
        hist_en_i = r.hist_en;
        hist_clear_i = r.hist_clr;
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            p = pi_rows[(ri + 3 * j) % pi_rows.size()];
            pi_ctl_i[j] = p.code;
            pi_cfg_i[j] = p.cfg;
            pi_exp[j] = p.exp_code;
        end
        pi_known = 1'b1;
        // previous sample is sliced with this cycle's level
        sym_q.push_back(expected_symbols(raw_q.pop_front(), int'(r.bit_level)));
        raw_q.push_back(raw);
        // enable and clear go with the symbols on the output now
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            tmp = cnt_next[l];
            if (r.hist_clr) begin
                cnt_next[l] = '0;
            end else if (r.hist_en) begin
                cnt_next[l] = tmp + count_level(vis_sym, l);
            end
            cnt_vis[l] = tmp;
        end
    endtask

    task automatic check_outputs();
        logic [SYM_W-1:0] exp_sym;
        exp_sym = sym_q.pop_front();
        vis_sym = exp_sym;
        n_checks++;
        if (symbols_o !== exp_sym) begin
            report_mismatch("symbols_o", symbols_o, exp_sym);
        end
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            n_checks++;
            if (hist_count_o[l] !== cnt_vis[l]) begin
                report_mismatch($sformatf("hist_count_o[%0d]", l), hist_count_o[l], cnt_vis[l]);
            end
        end
        n_checks++;
        if (ctl_valid_o !== 1'b1) begin
            report_mismatch("ctl_valid_o", ctl_valid_o, 1);
        end
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            n_checks++;
            if (pi_known && int_pi_ctl_o[j] !== pi_exp[j]) begin
                report_mismatch($sformatf("int_pi_ctl_o[%0d]", j), int_pi_ctl_o[j], pi_exp[j]);
            end
        end
    endtask

    task automatic wait_for_valid();
        int edges;
        logic seen;
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < VALID_TIMEOUT) begin
            @(negedge clk_adc);
            edges++;
            seen = ctl_valid_o;
        end
        n_checks++;
        if (!seen) begin
            timed_out = 1'b1;
            $display("timeout: ctl_valid_o did not rise within %0d edges", VALID_TIMEOUT);
        end else if (edges != dcore_pkg::WAIT_CYCLES) begin
            n_errors++;
            $display("** Error: ctl_valid_o rose at edge %0d after reset instead of edge %0d",
                     edges, dcore_pkg::WAIT_CYCLES);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        cdr_rstb = 1'b0;
        bit_level_i = '0;
        hist_en_i = 1'b0;
        hist_clear_i = 1'b0;
        for (int s = 0; s < dcore_pkg::N_TI; s++) begin
            adc_i[s] = '0;
        end
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            pi_ctl_i[j] = '0;
            pi_cfg_i[j] = '0;
        end
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            cnt_vis[l] = '0;
            cnt_next[l] = '0;
        end
        lfsr_state = 32'hdf4c;
        vis_sym = '0;
        pi_known = 1'b0;
        timed_out = 1'b0;
        n_checks = 0;
        n_errors = 0;
        build_tables();

        repeat (10) begin
            @(negedge clk_adc);
            n_checks++;
            if (ctl_valid_o !== 1'b0) begin
                report_mismatch("ctl_valid_o", ctl_valid_o, 0);
            end
        end
        // reset puts all lanes at the lowest level
        n_checks++;
        if (symbols_o !== '0) begin
            report_mismatch("symbols_o", symbols_o, 0);
        end
        for (int l = 0; l < dcore_pkg::N_LEVELS; l++) begin
            n_checks++;
            if (hist_count_o[l] !== '0) begin
                report_mismatch($sformatf("hist_count_o[%0d]", l), hist_count_o[l], 0);
            end
        end
        cdr_rstb = 1'b1;
        wait_for_valid();

        if (!timed_out) begin
            // idle inputs are in the pipe when the table starts
            raw_q.push_back('0);
            sym_q.push_back(expected_symbols('0, 0));
            for (int i = 0; i < rows.size(); i++) begin
                check_outputs();
                drive_row(i);
                @(negedge clk_adc);
            end
            check_outputs();
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/dcore_pkg.sv
verilog/adc_reorder.sv
slicer/pam4_slicer.sv
verilog/level_histogram.sv
verilog/pi_ctl_scaler.sv
verilog/digital_core.sv
tests/tb_digital_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the digital core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
        -f all.f --top-module tb_digital_core -o tb_digital_core; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_digital_core > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

# the log decides the result
if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
